// ==== all.f ====
card_pkg.sv
game_pkg.sv
card_dealer.sv
hand_scorer.sv
game_fsm.sv
coin_bank.sv
blackjack_top.sv
blackjack_chk.sv
tb_clock.sv
tb_blackjack.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_blackjack
FILELIST  = all.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_blackjack.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_blackjack;
    import card_pkg::*;
    import game_pkg::*;

    localparam int rounds       = 20;
    localparam int round_cycles = 200;
    localparam int clk_period   = 40;
    localparam int watchdog_ns  = (rounds * round_cycles + 12) * clk_period;

    // {next, hit, stand, double}
    localparam logic [3:0] key_next   = 4'b1000;
    localparam logic [3:0] key_hit    = 4'b0100;
    localparam logic [3:0] key_stand  = 4'b0010;
    localparam logic [3:0] key_double = 4'b0001;

    localparam int res_lose = 0;
    localparam int res_push = 1;
    localparam int res_win  = 2;

    logic               clk;
    logic               reset;
    logic               next;
    logic               hit;
    logic               stand;
    logic               double;
    logic [3:0]         bet;
    logic [card_w-1:0]  card;
    logic               card_valid;
    logic [score_w-1:0] player_score;
    logic [score_w-1:0] dealer_score;
    logic [coin_w-1:0]  coin;
    logic               win;
    logic               lose;
    logic               push;

    // hands as seen on the card bus
    int          player_hand[$];
    int          dealer_hand[$];
    int          dealer_before_last;
    int          player_owed;
    int          cards_seen;
    int          balance;
    bit          score_due;
    logic [31:0] rng;

    tb_clock #(.period_ns(clk_period), .reset_cycles(10)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    blackjack_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .next         (next),
        .hit          (hit),
        .stand        (stand),
        .double       (double),
        .bet          (bet),
        .card         (card),
        .card_valid   (card_valid),
        .player_score (player_score),
        .dealer_score (dealer_score),
        .coin         (coin),
        .win          (win),
        .lose         (lose),
        .push         (push)
    );

    // ------------------------------
    // reference model
    function automatic int hand_score(input int cards[$]);
        int sum;
        bit ace;
        sum = 0;
        ace = 1'b0;
        foreach (cards[i]) begin
            sum += cards[i];
            if (cards[i] == 1) begin
                ace = 1'b1;
            end
        end
        // one ace may count 11
        if (ace && sum + 10 <= 21) begin
            sum += 10;
        end
        return sum;
    endfunction

    function automatic int outcome(input int p, input int d);
        int res;
        if (p > 21) begin
            res = res_lose;
        end else if (d > 21 || p > d) begin
            res = res_win;
        end else if (p == d) begin
            res = res_push;
        end else begin
            res = res_lose;
        end
        return res;
    endfunction

    function automatic int payout(input int res, input int stake, input bit is_natural);
        int mult;
        if (res == res_win) begin
            mult = is_natural ? 3 : 2;
        end else if (res == res_push) begin
            mult = 1;
        end else begin
            mult = 0;
        end
        return stake * mult;
    endfunction

    // ------------------------------
    // random choices
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            rng   = lfsr_next(rng);
            value = (value << 1) | int'(rng[0]);
        end
    endtask

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic press(input logic [3:0] keys);
        {next, hit, stand, double} = keys;
        step();
        {next, hit, stand, double} = 4'b0000;
    endtask

    task automatic reject_bet(input int amount);
        int seen;
        seen = cards_seen;
        bet  = 4'(amount);
        press(key_next);
        repeat (8) step();
        check_value("cards after refused bet", cards_seen, seen);
        check_value("coin after refused bet", int'(coin), balance);
    endtask

    // ------------------------------
    // one round from bet to settlement
    task automatic play_round();
        int bits;
        int stake;
        int p;
        int d;
        int res;
        int size_before;
        bit doubled;
        bit early;
        bit done;
        doubled = 1'b0;
        done    = 1'b0;
        take_bits(1, bits);
        if (bits == 1) begin
            reject_bet((balance < 15) ? balance + 1 : 0);
        end
        take_bits(3, bits);
        stake = (bits + 1 > balance) ? balance : bits + 1;
        bet   = 4'(stake);
        press(key_next);
        check_value("coin after bet", int'(coin), balance - stake);
        balance -= stake;
        while (player_hand.size() + dealer_hand.size() < 4) begin
            step();
        end
        p     = hand_score(player_hand);
        d     = hand_score(dealer_hand);
        early = (p == 21) || (d == 21);
        while (!early && !done && hand_score(player_hand) < 21) begin
            // fsm leaves deal or drops busy first
            step();
            step();
            size_before = player_hand.size();
            take_bits(2, bits);
            if (bits == 0 && size_before == 2 && stake <= balance) begin
                player_owed++;
                press(key_double);
                check_value("coin after double", int'(coin), balance - stake);
                balance -= stake;
                stake   *= 2;
                doubled = 1'b1;
                done    = 1'b1;
                while (player_hand.size() == size_before) begin
                    step();
                end
            end else if (bits == 0 || bits == 3) begin
                press(key_stand);
                done = 1'b1;
            end else begin
                player_owed++;
                press(key_hit);
                while (player_hand.size() == size_before) begin
                    step();
                end
            end
        end
        while (!(win || lose || push)) begin
            step();
        end
        p   = hand_score(player_hand);
        d   = hand_score(dealer_hand);
        res = outcome(p, d);
        check_value("win flag", int'(win), int'(res == res_win));
        check_value("lose flag", int'(lose), int'(res == res_lose));
        check_value("push flag", int'(push), int'(res == res_push));
        if (doubled) begin
            check_value("player score after double", int'(player_score), p);
        end
        if (!early && p <= 21) begin
            check_value("dealer ended at 17 or more", int'(d >= 17), 1);
            if (dealer_hand.size() > 2) begin
                check_value("dealer drew below 17", int'(dealer_before_last < 17), 1);
            end
        end else begin
            check_value("dealer cards with no dealer turn", dealer_hand.size(), 2);
        end
        balance += payout(res, stake, player_hand.size() == 2 && p == 21);
        // bank settles one cycle after the outcome shows
        step();
        check_value("coin after settle", int'(coin), balance);
        press(key_next);
        player_hand.delete();
        dealer_hand.delete();
        player_owed = 0;
    endtask

    // ------------------------------
    // card monitor and score compare
    always @(negedge clk) begin : card_monitor
        int dealt;
        bit to_player;
        if (!reset) begin
            if (score_due) begin
                check_value("player score", int'(player_score), hand_score(player_hand));
                check_value("dealer score", int'(dealer_score), hand_score(dealer_hand));
            end
            score_due = card_valid;
            if (card_valid) begin
                cards_seen++;
                dealt = player_hand.size() + dealer_hand.size();
                // player, dealer, player, dealer, then whoever asked
                if (dealt < 4) begin
                    to_player = (dealt % 2 == 0);
                end else if (player_owed > 0) begin
                    to_player = 1'b1;
                    player_owed--;
                end else begin
                    to_player = 1'b0;
                end
                if (to_player) begin
                    player_hand.push_back(int'(card));
                end else begin
                    dealer_before_last = hand_score(dealer_hand);
                    dealer_hand.push_back(int'(card));
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("watchdog expired before all rounds finished");
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        next        = 1'b0;
        hit         = 1'b0;
        stand       = 1'b0;
        double      = 1'b0;
        bet         = 4'd0;
        rng         = 32'd70532;
        balance     = 30;
        player_owed = 0;
        cards_seen  = 0;
        score_due   = 1'b0;
        @(negedge reset);
        step();
        check_value("coin after reset", int'(coin), 30);
        reject_bet(0);
        for (int r = 0; r < rounds; r++) begin
            if (balance == 0 || balance > 200) begin
                break;
            end
            play_round();
        end
        if (u_dut.u_chk.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("assertion failures were reported during the run");
            $display("TESTBENCH FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // released just after a rising edge, like the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== blackjack_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module blackjack_chk (
    input logic                         clk,
    input logic                         reset,
    input logic [card_pkg::card_w-1:0]  card,
    input logic                         card_valid,
    input logic [card_pkg::score_w-1:0] player_score,
    input logic [card_pkg::score_w-1:0] dealer_score,
    input logic                         win,
    input logic                         lose,
    input logic                         push
);
    import card_pkg::*;

    // looked at by the testbench when the run ends
    int fail_count = 0;

    one_outcome: assert property (@(posedge clk) disable iff (reset)
        $onehot0({win, lose, push}))
        else begin
            $error("more than one outcome flag high");
            fail_count++;
        end

    card_range: assert property (@(posedge clk) disable iff (reset)
        card_valid |-> (card >= card_w'(1) && card <= card_w'(10)))
        else begin
            $error("card value outside 1 to 10");
            fail_count++;
        end

    // one card per draw, never back to back
    valid_gap: assert property (@(posedge clk) disable iff (reset)
        card_valid |=> !card_valid)
        else begin
            $error("card_valid high on two cycles in a row");
            fail_count++;
        end

    score_max: assert property (@(posedge clk) disable iff (reset)
        player_score <= score_w'(30) && dealer_score <= score_w'(30))
        else begin
            $error("hand score above 30");
            fail_count++;
        end

endmodule

bind blackjack_top blackjack_chk u_chk (
    .clk          (clk),
    .reset        (reset),
    .card         (card),
    .card_valid   (card_valid),
    .player_score (player_score),
    .dealer_score (dealer_score),
    .win          (win),
    .lose         (lose),
    .push         (push)
);

`default_nettype wire

// ==== blackjack_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module blackjack_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         next,
    input  logic                         hit,
    input  logic                         stand,
    input  logic                         double,
    input  logic [3:0]                   bet,
    output logic [card_pkg::card_w-1:0]  card,
    output logic                         card_valid,
    output logic [card_pkg::score_w-1:0] player_score,
    output logic [card_pkg::score_w-1:0] dealer_score,
    output logic [game_pkg::coin_w-1:0]  coin,
    output logic                         win,
    output logic                         lose,
    output logic                         push
);

    logic draw, to_dealer, clear;
    logic take_bet, take_double, settle, natural;
    logic bet_ok, double_ok;
    logic player_add, dealer_add;
    logic [2:0] player_cards;

    // ------------------------------
    // route each card to its hand
    assign player_add = card_valid && !to_dealer;
    assign dealer_add = card_valid && to_dealer;

    card_dealer u_card_dealer (
        .clk        (clk),
        .reset      (reset),
        .draw       (draw),
        .card       (card),
        .card_valid (card_valid)
    );

    hand_scorer u_player_hand (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .add        (player_add),
        .card       (card),
        .score      (player_score),
        .card_count (player_cards)
    );

    // dealer card count not needed
    hand_scorer u_dealer_hand (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .add        (dealer_add),
        .card       (card),
        .score      (dealer_score),
        .card_count ()
    );

    game_fsm u_game_fsm (
        .clk          (clk),
        .reset        (reset),
        .next         (next),
        .hit          (hit),
        .stand        (stand),
        .double       (double),
        .card_valid   (card_valid),
        .bet_ok       (bet_ok),
        .double_ok    (double_ok),
        .player_score (player_score),
        .dealer_score (dealer_score),
        .player_cards (player_cards),
        .draw         (draw),
        .to_dealer    (to_dealer),
        .clear        (clear),
        .take_bet     (take_bet),
        .take_double  (take_double),
        .settle       (settle),
        .natural      (natural),
        .win          (win),
        .lose         (lose),
        .push         (push)
    );

    coin_bank u_coin_bank (
        .clk         (clk),
        .reset       (reset),
        .bet         (bet),
        .take_bet    (take_bet),
        .take_double (take_double),
        .settle      (settle),
        .natural     (natural),
        .win         (win),
        .push        (push),
        .coin        (coin),
        .bet_ok      (bet_ok),
        .double_ok   (double_ok)
    );

endmodule

`default_nettype wire

// ==== coin_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module coin_bank (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [3:0]                  bet,
    input  logic                        take_bet,
    input  logic                        take_double,
    input  logic                        settle,
    input  logic                        natural,
    input  logic                        win,
    input  logic                        push,
    output logic [game_pkg::coin_w-1:0] coin,
    output logic                        bet_ok,
    output logic                        double_ok
);
    import game_pkg::*;

    logic [coin_w-1:0] stake;
    logic [coin_w-1:0] payout;
    logic [1:0]        mult;

    // ------------------------------
    // affordability
    assign bet_ok    = (bet != 4'd0) && (coin_w'(bet) <= coin);
    assign double_ok = stake <= coin;

    // stakes returned, nothing on a loss
    always_comb begin
        if (win) begin
            mult = natural ? pay_natural : pay_win;
        end else if (push) begin
            mult = pay_push;
        end else begin
            mult = 2'd0;
        end
        payout = stake * mult;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coin  <= initial_coin;
            stake <= '0;
        end else if (take_bet) begin
            coin  <= coin - coin_w'(bet);
            stake <= coin_w'(bet);
        end else if (take_double) begin
            // second stake of the same size
            coin  <= coin - stake;
            stake <= stake << 1;
        end else if (settle) begin
            coin <= coin + payout;
        end
    end

endmodule

`default_nettype wire

// ==== game_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         next,
    input  logic                         hit,
    input  logic                         stand,
    input  logic                         double,
    input  logic                         card_valid,
    input  logic                         bet_ok,
    input  logic                         double_ok,
    input  logic [card_pkg::score_w-1:0] player_score,
    input  logic [card_pkg::score_w-1:0] dealer_score,
    input  logic [2:0]                   player_cards,
    output logic                         draw,
    output logic                         to_dealer,
    output logic                         clear,
    output logic                         take_bet,
    output logic                         take_double,
    output logic                         settle,
    output logic                         natural,
    output logic                         win,
    output logic                         lose,
    output logic                         push
);
    import card_pkg::*;
    import game_pkg::*;

    logic [state_w-1:0] state, state_next;
    logic [2:0] deal_cnt;
    logic busy;
    logic doubled;
    logic issue, issue_dealer, enter_result;
    logic p_bust, d_bust, out_win, out_lose, out_push;

    // ------------------------------
    // outcome from the current scores
    assign p_bust   = player_score > bust_limit;
    assign d_bust   = dealer_score > bust_limit;
    assign out_win  = !p_bust && (d_bust || player_score > dealer_score);
    assign out_lose = p_bust || (!d_bust && dealer_score > player_score);
    assign out_push = !p_bust && !d_bust && (player_score == dealer_score);

    // ------------------------------
    // next state and command decode
    always_comb begin
        state_next   = state;
        issue        = 1'b0;
        issue_dealer = 1'b0;
        take_bet     = 1'b0;
        take_double  = 1'b0;
        case (state)
            st_betting: begin
                if (next && bet_ok) begin
                    take_bet   = 1'b1;
                    state_next = st_deal;
                end
            end
            st_deal: begin
                // player, dealer, player, dealer
                if (!busy) begin
                    if (deal_cnt != 3'd4) begin
                        issue        = 1'b1;
                        issue_dealer = deal_cnt[0];
                    end else if (player_score == bust_limit || dealer_score == bust_limit) begin
                        state_next = st_result;
                    end else begin
                        state_next = st_player;
                    end
                end
            end
            st_player: begin
                // commands ignored while a card is in flight
                if (!busy) begin
                    if (p_bust) begin
                        state_next = st_result;
                    end else if (doubled || player_score == bust_limit || stand) begin
                        state_next = st_dealer;
                    end else if (hit) begin
                        issue = 1'b1;
                    end else if (double && player_cards == 3'd2 && double_ok) begin
                        take_double = 1'b1;
                        issue       = 1'b1;
                    end
                end
            end
            st_dealer: begin
                if (!busy) begin
                    if (dealer_score < dealer_stand) begin
                        issue        = 1'b1;
                        issue_dealer = 1'b1;
                    end else begin
                        state_next = st_result;
                    end
                end
            end
            st_result: begin
                if (next) begin
                    state_next = st_betting;
                end
            end
            default: state_next = st_betting;
        endcase
    end

    assign enter_result = (state_next == st_result) && (state != st_result);
    assign clear        = (state == st_result) && next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= st_betting;
            draw      <= 1'b0;
            busy      <= 1'b0;
            to_dealer <= 1'b0;
            deal_cnt  <= 3'd0;
            doubled   <= 1'b0;
            settle    <= 1'b0;
            natural   <= 1'b0;
            win       <= 1'b0;
            lose      <= 1'b0;
            push      <= 1'b0;
        end else begin
            state  <= state_next;
            draw   <= issue;
            settle <= enter_result;
            // busy covers the draw and card_valid cycles
            if (issue) begin
                busy      <= 1'b1;
                to_dealer <= issue_dealer;
            end else if (card_valid) begin
                busy <= 1'b0;
            end
            if (state == st_betting) begin
                deal_cnt <= 3'd0;
                doubled  <= 1'b0;
            end else if (issue && state == st_deal) begin
                deal_cnt <= deal_cnt + 3'd1;
            end
            if (take_double) begin
                doubled <= 1'b1;
            end
            if (enter_result) begin
                win     <= out_win;
                lose    <= out_lose;
                push    <= out_push;
                natural <= (player_cards == 3'd2) && (player_score == bust_limit);
            end else if (clear) begin
                win     <= 1'b0;
                lose    <= 1'b0;
                push    <= 1'b0;
                natural <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hand_scorer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hand_scorer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         clear,
    input  logic                         add,
    input  logic [card_pkg::card_w-1:0]  card,
    output logic [card_pkg::score_w-1:0] score,
    output logic [2:0]                   card_count
);
    import card_pkg::*;

    // aces counted as 1 here
    logic [score_w-1:0] hard_sum;
    logic               ace_seen;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hard_sum   <= '0;
            ace_seen   <= 1'b0;
            card_count <= 3'd0;
        end else if (clear) begin
            hard_sum   <= '0;
            ace_seen   <= 1'b0;
            card_count <= 3'd0;
        end else if (add) begin
            hard_sum <= hard_sum + score_w'(card);
            if (card == card_w'(1)) begin
                ace_seen <= 1'b1;
            end
            // saturates, only the two-card case matters
            if (card_count != 3'd7) begin
                card_count <= card_count + 3'd1;
            end
        end
    end

    // ------------------------------
    // soft score
    // one ace may count 11 if the hand stays at 21 or below
    assign score = (ace_seen && hard_sum <= (bust_limit - ace_bonus)) ?
                   hard_sum + ace_bonus : hard_sum;

endmodule

`default_nettype wire

// ==== card_dealer.sv ====
`timescale 1ns/1ps
`default_nettype none

module card_dealer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       draw,
    output logic [card_pkg::card_w-1:0] card,
    output logic                       card_valid
);
    import card_pkg::*;

    logic [lfsr_w-1:0] lfsr;

    // 0, 14 and 15 become aces, face cards count 10
    function automatic logic [card_w-1:0] map_card(input logic [3:0] raw);
        logic [card_w-1:0] value;
        if (raw >= 4'd1 && raw <= 4'd9) begin
            value = card_w'(raw);
        end else if (raw >= 4'd10 && raw <= 4'd13) begin
            value = card_w'(10);
        end else begin
            value = card_w'(1);
        end
        return value;
    endfunction

    // free running, steps every cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr       <= lfsr_seed;
            card_valid <= 1'b0;
        end else begin
            lfsr       <= lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
            card_valid <= draw;
        end
    end

    always_ff @(posedge clk) begin
        if (draw) begin
            card <= map_card(lfsr[3:0]);
        end
    end

endmodule

`default_nettype wire

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

    // balance and stake width
    localparam int                coin_w       = 8;
    localparam logic [coin_w-1:0] initial_coin = 8'd30;

    // ------------------------------
    // game states
    localparam int                 state_w    = 3;
    localparam logic [state_w-1:0] st_betting = 3'd0;
    localparam logic [state_w-1:0] st_deal    = 3'd1;
    localparam logic [state_w-1:0] st_player  = 3'd2;
    localparam logic [state_w-1:0] st_dealer  = 3'd3;
    localparam logic [state_w-1:0] st_result  = 3'd4;

    // ------------------------------
    // stakes returned at settlement
    localparam logic [1:0] pay_win     = 2'd2;
    localparam logic [1:0] pay_natural = 2'd3;
    localparam logic [1:0] pay_push    = 2'd1;

endpackage

`default_nettype wire

// ==== card_pkg.sv ====
`default_nettype none

package card_pkg;

    // card and score sizes
    localparam int card_w  = 4;
    localparam int score_w = 5;

    // scoring limits
    localparam logic [score_w-1:0] bust_limit   = 5'd21;
    localparam logic [score_w-1:0] ace_bonus    = 5'd10;
    localparam logic [score_w-1:0] dealer_stand = 5'd17;

    // ------------------------------
    // dealing lfsr, galois form
    localparam int                lfsr_w    = 16;
    localparam logic [lfsr_w-1:0] lfsr_taps = 16'hb400;
    localparam logic [lfsr_w-1:0] lfsr_seed = 16'hace1;

endpackage

`default_nettype wire
